// ==== tb.f ====
verilog/machine_pkg.sv
verilog/mem_pkg.sv
verilog/l1i.sv
verilog/l1d.sv
verilog/mem_arbiter.sv
verilog/flush_tracker.sv
verilog/core_l1d_l1i.sv
testbench/tb_mem_model.sv
testbench/tb_core_l1d_l1i.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --assert --timescale 1ns/1ps -Wno-fatal
TOP       = tb_core_l1d_l1i
FILELIST  = tb.f
PASS_TEXT = TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf obj_dir

// ==== testbench/tb_core_l1d_l1i.sv ====
`default_nettype none

module tb_core_l1d_l1i;

   timeunit 1ns;
   timeprecision 1ps;

   localparam machine_pkg::word_t FILL_KEY = 32'h5a3c_96e1;
   localparam machine_pkg::addr_t CODE_BASE = 32'h0000_1000;
   localparam machine_pkg::addr_t DATA_BASE = 32'h0000_2000;
   localparam int TIMEOUT = 1000;
   localparam int OPS_PER_ROUND = 60;
   localparam int ROUNDS = 9;

   logic clk;
   logic reset;
   logic fetch_valid;
   machine_pkg::addr_t fetch_pc;
   logic core_mem_req_valid;
   mem_pkg::core_mem_req_t core_mem_req;
   logic flush_req_l1i;
   logic flush_req_l1d;
   logic mem_rsp_valid;
   machine_pkg::line_t mem_rsp_load_data;
   logic fetch_ack;
   logic fetch_rsp_valid;
   mem_pkg::fetch_rsp_t fetch_rsp;
   logic core_mem_req_ack;
   logic core_mem_rsp_valid;
   mem_pkg::core_mem_rsp_t core_mem_rsp;
   logic in_flush_mode;
   logic mem_req_valid;
   mem_pkg::mem_req_t mem_req;
   machine_pkg::counter_t l1i_cache_accesses;
   machine_pkg::counter_t l1i_cache_hits;
   machine_pkg::counter_t l1d_cache_accesses;
   machine_pkg::counter_t l1d_cache_hits;

   machine_pkg::word_t data_model [256];
   logic [15:0] icache_valid;    // shadow tag tables
   logic [23:0] icache_tag [16];
   logic [15:0] dcache_valid;
   logic [23:0] dcache_tag [16];
   machine_pkg::counter_t i_accesses;
   machine_pkg::counter_t i_hits;
   machine_pkg::counter_t d_accesses;
   machine_pkg::counter_t d_hits;

   core_l1d_l1i DUT (.*);

   tb_mem_model #(.FILL_KEY(FILL_KEY)) mem (.*);

   always #4 clk = ~clk;

   function automatic machine_pkg::word_t preset_word(machine_pkg::addr_t addr);
      return addr ^ FILL_KEY;
   endfunction

   task automatic compare_values(string name, logic [63:0] got, logic [63:0] expected);
      if (got !== expected)
      begin
         $display("ERROR at %0t: %s got %0h expected %0h", $time, name, got, expected);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
   endtask

   task automatic report_timeout(string what);
      $display("timed out at %0t while waiting for %s", $time, what);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic wait_cycle(inout int cycles, input string what);
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT)
         report_timeout(what);
   endtask

   task automatic run_fetches(int count);
      machine_pkg::addr_t pc;
      logic hit;
      int cycles;
      for (int n = 0; n < count; n++)
      begin
         pc = CODE_BASE + (machine_pkg::addr_t'($urandom_range(255, 0)) << 2);
         fetch_valid <= 1'b1;
         fetch_pc <= pc;
         cycles = 0;
         do
            wait_cycle(cycles, "fetch_ack");
         while (!fetch_ack);
         fetch_valid <= 1'b0;
         i_accesses = i_accesses + 1;
         // index is pc[7:4], tag the bits above
         hit = icache_valid[pc[7:4]] && (icache_tag[pc[7:4]] == pc[31:8]);
         icache_valid[pc[7:4]] = 1'b1;
         icache_tag[pc[7:4]] = pc[31:8];
         if (hit)
            i_hits = i_hits + 1;
         cycles = 0;
         do
            wait_cycle(cycles, "fetch_rsp_valid");
         while (!fetch_rsp_valid);
         if (hit)
            compare_values("fetch hit latency", cycles, 2);
         compare_values("fetch_rsp.pc", fetch_rsp.pc, pc);
         compare_values("fetch_rsp.insn", fetch_rsp.insn, preset_word(pc));
      end
   endtask

   task automatic run_data_ops(int count);
      machine_pkg::addr_t addr;
      machine_pkg::word_t wdata;
      logic is_store;
      logic hit;
      int slot;
      int cycles;
      for (int n = 0; n < count; n++)
      begin
         slot = $urandom_range(255, 0);
         addr = DATA_BASE + machine_pkg::addr_t'(slot << 2);
         wdata = $urandom;
         is_store = 1'($urandom_range(1, 0));
         core_mem_req_valid <= 1'b1;
         core_mem_req.addr <= addr;
         core_mem_req.store_data <= wdata;
         core_mem_req.is_store <= is_store;
         cycles = 0;
         do
            wait_cycle(cycles, "core_mem_req_ack");
         while (!core_mem_req_ack);
         core_mem_req_valid <= 1'b0;
         d_accesses = d_accesses + 1;
         hit = dcache_valid[addr[7:4]] && (dcache_tag[addr[7:4]] == addr[31:8]);
         dcache_valid[addr[7:4]] = 1'b1;
         dcache_tag[addr[7:4]] = addr[31:8];
         if (hit)
            d_hits = d_hits + 1;
         cycles = 0;
         do
            wait_cycle(cycles, "core_mem_rsp_valid");
         while (!core_mem_rsp_valid);
         if (hit)
            compare_values("data hit latency", cycles, 2);
         compare_values("core_mem_rsp.addr", core_mem_rsp.addr, addr);
         compare_values("core_mem_rsp.load_data", core_mem_rsp.load_data, data_model[slot]);
         if (is_store)
            data_model[slot] = wdata;    // response carried the old word
      end
   endtask

   task automatic check_memory_image();
      machine_pkg::line_t line;
      machine_pkg::addr_t addr;
      for (int k = 0; k < 64; k++)
      begin
         line = mem.lines[(DATA_BASE >> 4) + k];
         for (int w = 0; w < 4; w++)
         begin
            addr = DATA_BASE + machine_pkg::addr_t'(k * 16 + w * 4);
            compare_values($sformatf("memory word %h", addr), line[w*32 +: 32],
                           data_model[k*4 + w]);
         end
      end
   endtask

   task automatic run_flush(logic do_l1i, logic do_l1d);
      int cycles;
      int high_cycles;
      flush_req_l1i <= do_l1i;
      flush_req_l1d <= do_l1d;
      @(posedge clk);
      flush_req_l1i <= 1'b0;
      flush_req_l1d <= 1'b0;
      @(posedge clk);
      compare_values("in_flush_mode", in_flush_mode, 1'b1);
      high_cycles = 0;
      cycles = 0;
      while (in_flush_mode)
      begin
         high_cycles++;
         wait_cycle(cycles, "in_flush_mode to fall");
      end
      if (do_l1i)
      begin
         compare_values("l1i flush at least 16 cycles", high_cycles >= 16, 1'b1);
         icache_valid = '0;
      end
      if (do_l1d)
      begin
         dcache_valid = '0;    // all lines written back and invalid
         check_memory_image();
      end
   endtask

   // code lines belong to the l1i, data lines to the l1d
   always @(posedge clk)
   begin
      if (!reset && mem_req_valid)
         compare_values("mem_req.tag", mem_req.tag,
                        (mem_req.addr < DATA_BASE) ? 2'd1 : 2'd0);
   end

   initial
   begin
      void'($urandom(56693));
      clk = 1'b0;
      reset = 1'b1;
      fetch_valid = 1'b0;
      fetch_pc = '0;
      core_mem_req_valid = 1'b0;
      core_mem_req = '0;
      flush_req_l1i = 1'b0;
      flush_req_l1d = 1'b0;
      icache_valid = '0;
      dcache_valid = '0;
      i_accesses = '0;
      i_hits = '0;
      d_accesses = '0;
      d_hits = '0;
      for (int i = 0; i < 256; i++)
         data_model[i] = preset_word(DATA_BASE + machine_pkg::addr_t'(i * 4));
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      compare_values("fetch_rsp_valid", fetch_rsp_valid, 1'b0);
      compare_values("core_mem_rsp_valid", core_mem_rsp_valid, 1'b0);
      compare_values("mem_req_valid", mem_req_valid, 1'b0);
      compare_values("in_flush_mode", in_flush_mode, 1'b0);
      // rotate l1d, l1i and combined flushes between rounds
      for (int r = 0; r < ROUNDS; r++)
      begin
         fork
            run_fetches(OPS_PER_ROUND);
            run_data_ops(OPS_PER_ROUND);
         join
         run_flush(r % 3 != 0, r % 3 != 1);
      end
      compare_values("l1i_cache_accesses", l1i_cache_accesses, i_accesses);
      compare_values("l1i_cache_hits", l1i_cache_hits, i_hits);
      compare_values("l1d_cache_accesses", l1d_cache_accesses, d_accesses);
      compare_values("l1d_cache_hits", l1d_cache_hits, d_hits);
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/tb_mem_model.sv ====
`default_nettype none

module tb_mem_model
#(
   parameter machine_pkg::word_t FILL_KEY = '0
)
(
   input wire clk,
   input wire reset,
   input wire mem_req_valid,
   input wire mem_pkg::mem_req_t mem_req,
   output logic mem_rsp_valid,
   output machine_pkg::line_t mem_rsp_load_data
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int LG_LINES = 10;    // 16 KB, code and data regions
   localparam int NUM_LINES = 1 << LG_LINES;

   machine_pkg::line_t lines [NUM_LINES];
   logic busy;
   int unsigned wait_left;
   logic [LG_LINES-1:0] line_idx;

   assign line_idx = mem_req.addr[machine_pkg::LG_CL_LEN +: LG_LINES];

   // every word holds its own byte address xor the key
   function automatic machine_pkg::line_t preset_line(int idx);
      machine_pkg::line_t line;
      for (int w = 0; w < 4; w++)
         line[w*32 +: 32] = machine_pkg::word_t'(idx * 16 + w * 4) ^ FILL_KEY;
      return line;
   endfunction

   always @(posedge clk)
   begin
      if (reset)
      begin
         busy <= 1'b0;
         wait_left <= 0;
         mem_rsp_valid <= 1'b0;
         mem_rsp_load_data <= '0;
         for (int i = 0; i < NUM_LINES; i++)
            lines[i] <= preset_line(i);
      end
      else
      begin
         mem_rsp_valid <= 1'b0;
         if (busy)
         begin
            if (wait_left == 0)
            begin
               busy <= 1'b0;
               mem_rsp_valid <= 1'b1;
               if (mem_req.opcode == mem_pkg::MEM_STORE_CL)
                  lines[line_idx] <= mem_req.store_data;
               else
                  mem_rsp_load_data <= lines[line_idx];
            end
            else
               wait_left <= wait_left - 1;
         end
         else if (mem_req_valid && !mem_rsp_valid)    // request still up in the answer cycle
         begin
            busy <= 1'b1;
            wait_left <= $urandom_range(7, 0);    // 1 to 8 cycles
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/core_l1d_l1i.sv ====
`default_nettype none

module core_l1d_l1i
(
   input wire clk,
   input wire reset,
   input wire fetch_valid,
   input wire machine_pkg::addr_t fetch_pc,
   input wire core_mem_req_valid,
   input wire mem_pkg::core_mem_req_t core_mem_req,
   input wire flush_req_l1i,
   input wire flush_req_l1d,
   input wire mem_rsp_valid,
   input wire machine_pkg::line_t mem_rsp_load_data,
   output logic fetch_ack,
   output logic fetch_rsp_valid,
   output mem_pkg::fetch_rsp_t fetch_rsp,
   output logic core_mem_req_ack,
   output logic core_mem_rsp_valid,
   output mem_pkg::core_mem_rsp_t core_mem_rsp,
   output logic in_flush_mode,
   output logic mem_req_valid,
   output mem_pkg::mem_req_t mem_req,
   output machine_pkg::counter_t l1i_cache_accesses,
   output machine_pkg::counter_t l1i_cache_hits,
   output machine_pkg::counter_t l1d_cache_accesses,
   output machine_pkg::counter_t l1d_cache_hits
);

   logic l1i_mem_req_valid;
   mem_pkg::mem_req_t l1i_mem_req;
   logic l1i_mem_rsp_valid;
   logic l1d_mem_req_valid;
   mem_pkg::mem_req_t l1d_mem_req;
   logic l1d_mem_rsp_valid;
   logic l1i_flush_complete;
   logic l1d_flush_complete;

   l1i icache (
      .clk(clk),
      .reset(reset),
      .fetch_valid(fetch_valid),
      .fetch_pc(fetch_pc),
      .flush_req(flush_req_l1i),
      .mem_rsp_valid(l1i_mem_rsp_valid),
      .mem_rsp_load_data(mem_rsp_load_data),
      .fetch_ack(fetch_ack),
      .fetch_rsp_valid(fetch_rsp_valid),
      .fetch_rsp(fetch_rsp),
      .flush_complete(l1i_flush_complete),
      .mem_req_valid(l1i_mem_req_valid),
      .mem_req(l1i_mem_req),
      .cache_accesses(l1i_cache_accesses),
      .cache_hits(l1i_cache_hits)
   );

   l1d dcache (
      .clk(clk),
      .reset(reset),
      .core_mem_req_valid(core_mem_req_valid),
      .core_mem_req(core_mem_req),
      .flush_req(flush_req_l1d),
      .mem_rsp_valid(l1d_mem_rsp_valid),
      .mem_rsp_load_data(mem_rsp_load_data),
      .core_mem_req_ack(core_mem_req_ack),
      .core_mem_rsp_valid(core_mem_rsp_valid),
      .core_mem_rsp(core_mem_rsp),
      .flush_complete(l1d_flush_complete),
      .mem_req_valid(l1d_mem_req_valid),
      .mem_req(l1d_mem_req),
      .cache_accesses(l1d_cache_accesses),
      .cache_hits(l1d_cache_hits)
   );

   mem_arbiter arbiter (
      .clk(clk),
      .reset(reset),
      .l1i_mem_req_valid(l1i_mem_req_valid),
      .l1i_mem_req(l1i_mem_req),
      .l1d_mem_req_valid(l1d_mem_req_valid),
      .l1d_mem_req(l1d_mem_req),
      .ext_mem_rsp_valid(mem_rsp_valid),
      .l1i_mem_rsp_valid(l1i_mem_rsp_valid),
      .l1d_mem_rsp_valid(l1d_mem_rsp_valid),
      .ext_mem_req_valid(mem_req_valid),
      .ext_mem_req(mem_req)
   );

   flush_tracker flusher (
      .clk(clk),
      .reset(reset),
      .flush_req_l1i(flush_req_l1i),
      .flush_req_l1d(flush_req_l1d),
      .l1i_flush_complete(l1i_flush_complete),
      .l1d_flush_complete(l1d_flush_complete),
      .in_flush_mode(in_flush_mode)
   );

endmodule

`default_nettype wire

// ==== verilog/flush_tracker.sv ====
`default_nettype none

module flush_tracker
(
   input wire clk,
   input wire reset,
   input wire flush_req_l1i,
   input wire flush_req_l1d,
   input wire l1i_flush_complete,
   input wire l1d_flush_complete,
   output logic in_flush_mode
);

   typedef enum logic [1:0] {
      FLUSH_IDLE,
      WAIT_FOR_L1D_L1I,
      GOT_L1D,
      GOT_L1I
   } flush_state_t;

   flush_state_t r_state, n_state;

   assign in_flush_mode = (r_state != FLUSH_IDLE);

   always_comb
   begin
      n_state = r_state;
      case (r_state)
         FLUSH_IDLE:
            if (flush_req_l1i && flush_req_l1d)
               n_state = WAIT_FOR_L1D_L1I;
            else if (flush_req_l1i)
               n_state = GOT_L1D;    // l1d not involved
            else if (flush_req_l1d)
               n_state = GOT_L1I;
         WAIT_FOR_L1D_L1I:
            if (l1d_flush_complete && l1i_flush_complete)
               n_state = FLUSH_IDLE;
            else if (l1d_flush_complete)
               n_state = GOT_L1D;
            else if (l1i_flush_complete)
               n_state = GOT_L1I;
         GOT_L1D:
            if (l1i_flush_complete)
               n_state = FLUSH_IDLE;
         GOT_L1I:
            if (l1d_flush_complete)
               n_state = FLUSH_IDLE;
         default:
            n_state = FLUSH_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         r_state <= FLUSH_IDLE;
      else
         r_state <= n_state;
   end

   // core waits for the flush before asking again
   a_no_nested_flush: assert property (@(posedge clk) disable iff (reset)
      in_flush_mode |-> !(flush_req_l1i || flush_req_l1d));

endmodule

`default_nettype wire

// ==== verilog/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter
(
   input wire clk,
   input wire reset,
   input wire l1i_mem_req_valid,
   input wire mem_pkg::mem_req_t l1i_mem_req,
   input wire l1d_mem_req_valid,
   input wire mem_pkg::mem_req_t l1d_mem_req,
   input wire ext_mem_rsp_valid,
   output logic l1i_mem_rsp_valid,
   output logic l1d_mem_rsp_valid,
   output logic ext_mem_req_valid,
   output mem_pkg::mem_req_t ext_mem_req
);

   typedef enum logic [1:0] {
      IDLE,
      GNT_L1D,
      GNT_L1I
   } state_t;

   state_t r_state, n_state;
   logic r_l1d_req, n_l1d_req;    // latched request pulses
   logic r_l1i_req, n_l1i_req;
   logic r_last_gnt, n_last_gnt;    // set when the l1i was served last

   assign ext_mem_req_valid = (r_state != IDLE);
   assign ext_mem_req = (r_state == GNT_L1I) ? l1i_mem_req : l1d_mem_req;
   assign l1d_mem_rsp_valid = (r_state == GNT_L1D) && ext_mem_rsp_valid;
   assign l1i_mem_rsp_valid = (r_state == GNT_L1I) && ext_mem_rsp_valid;

   always_comb
   begin
      n_state = r_state;
      n_last_gnt = r_last_gnt;
      n_l1d_req = r_l1d_req || l1d_mem_req_valid;
      n_l1i_req = r_l1i_req || l1i_mem_req_valid;
      case (r_state)
         IDLE:
            if (n_l1d_req && n_l1i_req)
               n_state = r_last_gnt ? GNT_L1D : GNT_L1I;
            else if (n_l1d_req)
               n_state = GNT_L1D;
            else if (n_l1i_req)
               n_state = GNT_L1I;
         GNT_L1D:
         begin
            n_last_gnt = 1'b0;
            n_l1d_req = 1'b0;
            if (ext_mem_rsp_valid)
               n_state = IDLE;
         end
         GNT_L1I:
         begin
            n_last_gnt = 1'b1;
            n_l1i_req = 1'b0;
            if (ext_mem_rsp_valid)
               n_state = IDLE;
         end
         default:
            n_state = IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= IDLE;
         r_last_gnt <= 1'b0;
         r_l1d_req <= 1'b0;
         r_l1i_req <= 1'b0;
      end
      else
      begin
         r_state <= n_state;
         r_last_gnt <= n_last_gnt;
         r_l1d_req <= n_l1d_req;
         r_l1i_req <= n_l1i_req;
      end
   end

   // granted request holds until memory answers
   a_req_held: assert property (@(posedge clk) disable iff (reset)
      ext_mem_req_valid && !ext_mem_rsp_valid |=> ext_mem_req_valid && $stable(ext_mem_req));

endmodule

`default_nettype wire

// ==== verilog/l1d.sv ====
`default_nettype none

module l1d
(
   input wire clk,
   input wire reset,
   input wire core_mem_req_valid,
   input wire mem_pkg::core_mem_req_t core_mem_req,
   input wire flush_req,
   input wire mem_rsp_valid,
   input wire machine_pkg::line_t mem_rsp_load_data,
   output logic core_mem_req_ack,
   output logic core_mem_rsp_valid,
   output mem_pkg::core_mem_rsp_t core_mem_rsp,
   output logic flush_complete,
   output logic mem_req_valid,
   output mem_pkg::mem_req_t mem_req,
   output machine_pkg::counter_t cache_accesses,
   output machine_pkg::counter_t cache_hits
);

   localparam int LINES = 1 << machine_pkg::LG_L1D_LINES;
   localparam int TAG_LSB = machine_pkg::LG_CL_LEN + machine_pkg::LG_L1D_LINES;

   typedef enum logic [2:0] {
      IDLE,
      WB_WAIT,
      REFILL_WAIT,
      FLUSH_SCAN,
      FLUSH_WB_WAIT
   } state_t;

   state_t r_state;
   machine_pkg::l1d_tag_t r_tag [LINES];
   machine_pkg::line_t r_data [LINES];
   logic [LINES-1:0] r_valid;
   logic [LINES-1:0] r_dirty;
   mem_pkg::core_mem_req_t r_req;
   machine_pkg::l1d_idx_t r_flush_idx;
   logic r_lookup;
   logic r_flush_pend;

   machine_pkg::l1d_idx_t idx;       // line of the current request
   machine_pkg::l1d_idx_t wb_idx;    // line going out to memory
   machine_pkg::l1d_tag_t tag;
   logic [1:0] word_sel;
   logic accept;
   logic hit;
   logic hit_now;
   logic fill;
   logic line_we;
   logic flush_step;
   machine_pkg::line_t line_in;
   machine_pkg::line_t line_new;
   machine_pkg::word_t old_word;

   assign idx = machine_pkg::l1d_idx_t'(r_req.addr >> machine_pkg::LG_CL_LEN);
   assign tag = machine_pkg::l1d_tag_t'(r_req.addr >> TAG_LSB);
   assign word_sel = r_req.addr[machine_pkg::LG_CL_LEN-1:2];
   assign wb_idx = (r_state == WB_WAIT) ? idx : r_flush_idx;

   assign core_mem_req_ack = (r_state == IDLE) && !r_lookup && !r_flush_pend && !flush_req;
   assign accept = core_mem_req_valid && core_mem_req_ack;
   assign hit = r_valid[idx] && (r_tag[idx] == tag);
   assign hit_now = (r_state == IDLE) && r_lookup && hit;
   assign fill = (r_state == REFILL_WAIT) && mem_rsp_valid;
   assign line_we = fill || (hit_now && r_req.is_store);
   // clean lines pass in one cycle, dirty ones after their writeback
   assign flush_step = ((r_state == FLUSH_SCAN) && !(r_valid[r_flush_idx] && r_dirty[r_flush_idx]))
                       || ((r_state == FLUSH_WB_WAIT) && mem_rsp_valid);

   always_comb
   begin
      line_in = fill ? mem_rsp_load_data : r_data[idx];
      old_word = line_in[{word_sel, 5'd0} +: 32];
      line_new = line_in;
      if (r_req.is_store)
         line_new[{word_sel, 5'd0} +: 32] = r_req.store_data;
   end

   assign mem_req.addr = (r_state == REFILL_WAIT)
                         ? {r_req.addr[machine_pkg::M_WIDTH-1:machine_pkg::LG_CL_LEN],
                            {machine_pkg::LG_CL_LEN{1'b0}}}
                         : {r_tag[wb_idx], wb_idx, {machine_pkg::LG_CL_LEN{1'b0}}};
   assign mem_req.store_data = r_data[wb_idx];
   assign mem_req.tag = mem_pkg::L1D_MEM_TAG;
   assign mem_req.opcode = (r_state == REFILL_WAIT) ? mem_pkg::MEM_LOAD_CL
                                                    : mem_pkg::MEM_STORE_CL;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= IDLE;
         r_valid <= '0;
         r_dirty <= '0;
         r_lookup <= 1'b0;
         r_flush_pend <= 1'b0;
         r_flush_idx <= '0;
         core_mem_rsp_valid <= 1'b0;
         flush_complete <= 1'b0;
         mem_req_valid <= 1'b0;
         cache_accesses <= '0;
         cache_hits <= '0;
      end
      else
      begin
         core_mem_rsp_valid <= hit_now || fill;
         flush_complete <= 1'b0;
         mem_req_valid <= 1'b0;
         if (flush_req)
            r_flush_pend <= 1'b1;
         if (line_we)
         begin
            r_valid[idx] <= 1'b1;
            r_dirty[idx] <= r_req.is_store;
         end
         case (r_state)
            IDLE:
            begin
               if (r_lookup)
               begin
                  if (hit)
                  begin
                     r_lookup <= 1'b0;
                     cache_hits <= cache_hits + 1'b1;
                  end
                  else
                  begin
                     // dirty victim goes out before the refill
                     r_state <= (r_valid[idx] && r_dirty[idx]) ? WB_WAIT : REFILL_WAIT;
                     mem_req_valid <= 1'b1;
                  end
               end
               else if (flush_req || r_flush_pend)
               begin
                  r_state <= FLUSH_SCAN;
                  r_flush_idx <= '0;
                  r_flush_pend <= 1'b0;
               end
               else if (accept)
               begin
                  r_lookup <= 1'b1;
                  cache_accesses <= cache_accesses + 1'b1;
               end
            end
            WB_WAIT:
               if (mem_rsp_valid)
               begin
                  r_state <= REFILL_WAIT;
                  mem_req_valid <= 1'b1;
               end
            REFILL_WAIT:
               if (mem_rsp_valid)
               begin
                  r_lookup <= 1'b0;
                  r_state <= IDLE;
               end
            FLUSH_SCAN:
               if (!flush_step)
               begin
                  r_state <= FLUSH_WB_WAIT;
                  mem_req_valid <= 1'b1;
               end
            default:
               ;
         endcase
         if (flush_step)
         begin
            r_valid[r_flush_idx] <= 1'b0;
            r_dirty[r_flush_idx] <= 1'b0;
            r_flush_idx <= r_flush_idx + 1'b1;
            r_state <= (r_flush_idx == '1) ? IDLE : FLUSH_SCAN;
            flush_complete <= (r_flush_idx == '1);
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         r_req <= core_mem_req;
      if (line_we)
      begin
         r_data[idx] <= line_new;
         r_tag[idx] <= tag;
      end
      core_mem_rsp.addr <= r_req.addr;
      core_mem_rsp.load_data <= old_word;
   end

   // no taken request is pending while the flush walks the lines
   a_no_accept_in_flush: assert property (@(posedge clk) disable iff (reset)
      (r_state == FLUSH_SCAN || r_state == FLUSH_WB_WAIT) |-> !r_lookup);

endmodule

`default_nettype wire

// ==== verilog/l1i.sv ====
`default_nettype none

module l1i
(
   input wire clk,
   input wire reset,
   input wire fetch_valid,
   input wire machine_pkg::addr_t fetch_pc,
   input wire flush_req,
   input wire mem_rsp_valid,
   input wire machine_pkg::line_t mem_rsp_load_data,
   output logic fetch_ack,
   output logic fetch_rsp_valid,
   output mem_pkg::fetch_rsp_t fetch_rsp,
   output logic flush_complete,
   output logic mem_req_valid,
   output mem_pkg::mem_req_t mem_req,
   output machine_pkg::counter_t cache_accesses,
   output machine_pkg::counter_t cache_hits
);

   localparam int LINES = 1 << machine_pkg::LG_L1I_LINES;
   localparam int TAG_LSB = machine_pkg::LG_CL_LEN + machine_pkg::LG_L1I_LINES;

   typedef enum logic [1:0] {
      IDLE,
      MISS_WAIT,
      FLUSH_WALK
   } state_t;

   state_t r_state;
   machine_pkg::l1i_tag_t r_tag [LINES];
   machine_pkg::line_t r_data [LINES];
   logic [LINES-1:0] r_valid;
   machine_pkg::addr_t r_pc;
   machine_pkg::l1i_idx_t r_flush_idx;
   logic r_lookup;    // taken fetch waiting for its tag check
   logic r_flush_pend;

   machine_pkg::l1i_idx_t idx;
   machine_pkg::l1i_tag_t tag;
   logic [1:0] word_sel;
   logic hit;
   logic hit_now;
   logic fill;

   assign idx = machine_pkg::l1i_idx_t'(r_pc >> machine_pkg::LG_CL_LEN);
   assign tag = machine_pkg::l1i_tag_t'(r_pc >> TAG_LSB);
   assign word_sel = r_pc[machine_pkg::LG_CL_LEN-1:2];

   assign hit = r_valid[idx] && (r_tag[idx] == tag);
   assign hit_now = (r_state == IDLE) && r_lookup && hit;
   assign fill = (r_state == MISS_WAIT) && mem_rsp_valid;
   assign fetch_ack = (r_state == IDLE) && !r_lookup && !r_flush_pend && !flush_req;

   assign mem_req.addr = {r_pc[machine_pkg::M_WIDTH-1:machine_pkg::LG_CL_LEN],
                          {machine_pkg::LG_CL_LEN{1'b0}}};
   assign mem_req.store_data = '0;
   assign mem_req.tag = mem_pkg::L1I_MEM_TAG;
   assign mem_req.opcode = mem_pkg::MEM_LOAD_CL;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= IDLE;
         r_valid <= '0;
         r_lookup <= 1'b0;
         r_flush_pend <= 1'b0;
         r_flush_idx <= '0;
         fetch_rsp_valid <= 1'b0;
         flush_complete <= 1'b0;
         mem_req_valid <= 1'b0;
         cache_accesses <= '0;
         cache_hits <= '0;
      end
      else
      begin
         fetch_rsp_valid <= hit_now || fill;
         flush_complete <= 1'b0;
         mem_req_valid <= 1'b0;
         if (flush_req)
            r_flush_pend <= 1'b1;    // held over a miss
         case (r_state)
            IDLE:
            begin
               if (r_lookup)
               begin
                  if (hit)
                  begin
                     r_lookup <= 1'b0;
                     cache_hits <= cache_hits + 1'b1;
                  end
                  else
                  begin
                     r_state <= MISS_WAIT;
                     mem_req_valid <= 1'b1;
                  end
               end
               else if (flush_req || r_flush_pend)
               begin
                  r_state <= FLUSH_WALK;
                  r_flush_idx <= '0;
                  r_flush_pend <= 1'b0;
               end
               else if (fetch_valid && fetch_ack)
               begin
                  r_lookup <= 1'b1;
                  cache_accesses <= cache_accesses + 1'b1;
               end
            end
            MISS_WAIT:
               if (mem_rsp_valid)
               begin
                  r_valid[idx] <= 1'b1;
                  r_lookup <= 1'b0;
                  r_state <= IDLE;
               end
            FLUSH_WALK:
            begin
               r_valid[r_flush_idx] <= 1'b0;    // one line per cycle
               r_flush_idx <= r_flush_idx + 1'b1;
               if (r_flush_idx == '1)
               begin
                  flush_complete <= 1'b1;
                  r_state <= IDLE;
               end
            end
            default:
               r_state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (fetch_valid && fetch_ack)
         r_pc <= fetch_pc;
      if (fill)
      begin
         r_data[idx] <= mem_rsp_load_data;
         r_tag[idx] <= tag;
      end
      fetch_rsp.pc <= r_pc;
      fetch_rsp.insn <= fill ? mem_rsp_load_data[{word_sel, 5'd0} +: 32]
                             : r_data[idx][{word_sel, 5'd0} +: 32];
   end

   // no taken fetch is left pending while the walk clears lines
   a_no_fetch_in_flush: assert property (@(posedge clk) disable iff (reset)
      (r_state == FLUSH_WALK) |-> !r_lookup);

endmodule

`default_nettype wire

// ==== verilog/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

   localparam int LG_MEM_TAG_ENTRIES = 2;

   typedef logic [LG_MEM_TAG_ENTRIES-1:0] mem_tag_t;

   // fixed owner tags, visible on the memory port
   localparam mem_tag_t L1D_MEM_TAG = 2'd0;
   localparam mem_tag_t L1I_MEM_TAG = 2'd1;

   typedef enum logic [3:0] {
      MEM_LOAD_CL  = 4'd0,    // line refill
      MEM_STORE_CL = 4'd1     // line writeback
   } mem_opcode_t;

   typedef struct packed {
      machine_pkg::addr_t addr;
      machine_pkg::line_t store_data;
      mem_tag_t tag;
      mem_opcode_t opcode;
   } mem_req_t;

   typedef struct packed {
      machine_pkg::addr_t addr;
      machine_pkg::word_t store_data;
      logic is_store;
   } core_mem_req_t;

   typedef struct packed {
      machine_pkg::addr_t addr;
      machine_pkg::word_t load_data;    // old word on a store
   } core_mem_rsp_t;

   typedef struct packed {
      machine_pkg::addr_t pc;
      machine_pkg::word_t insn;
   } fetch_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/machine_pkg.sv ====
`default_nettype none

package machine_pkg;

   localparam int M_WIDTH = 32;
   localparam int LG_CL_LEN = 4;    // 16-byte lines
   localparam int CL_LEN_BITS = 1 << (LG_CL_LEN + 3);
   localparam int LG_L1I_LINES = 4;
   localparam int LG_L1D_LINES = 4;
   localparam int L1I_TAG_BITS = M_WIDTH - LG_CL_LEN - LG_L1I_LINES;
   localparam int L1D_TAG_BITS = M_WIDTH - LG_CL_LEN - LG_L1D_LINES;

   typedef logic [M_WIDTH-1:0] addr_t;
   typedef logic [31:0] word_t;
   typedef logic [CL_LEN_BITS-1:0] line_t;

   typedef logic [LG_L1I_LINES-1:0] l1i_idx_t;
   typedef logic [LG_L1D_LINES-1:0] l1d_idx_t;
   typedef logic [L1I_TAG_BITS-1:0] l1i_tag_t;
   typedef logic [L1D_TAG_BITS-1:0] l1d_tag_t;

   typedef logic [63:0] counter_t;

endpackage

`default_nettype wire
